// ==== rtl/scache_pkg.sv ====
// Data cache slice shared definitions
// Widths, opcode and AMO encodings, packet and decode structs
package scache_pkg;

  localparam int data_width_lp = 64;
  localparam int addr_width_lp = 11;
  localparam int mask_width_lp = data_width_lp / 8;
  localparam int mem_depth_lp = 256;
  localparam int word_idx_width_lp = $clog2(mem_depth_lp);
  localparam int byte_off_width_lp = $clog2(mask_width_lp);

  typedef logic [data_width_lp-1:0] data_t;
  typedef logic [addr_width_lp-1:0] addr_t;
  typedef logic [mask_width_lp-1:0] mask_t;
  typedef logic [word_idx_width_lp-1:0] word_idx_t;
  typedef logic [byte_off_width_lp-1:0] byte_off_t;

  typedef enum logic [1:0] {
    e_size_byte   = 2'b00,
    e_size_half   = 2'b01,
    e_size_word   = 2'b10,
    e_size_double = 2'b11
  } size_e;

  // Low 4 bits of the AMO opcodes match the sub-op
  typedef enum logic [5:0] {
    LB        = 6'b000000,
    LH        = 6'b000001,
    LW        = 6'b000010,
    LD        = 6'b000011,
    LBU       = 6'b000100,
    LHU       = 6'b000101,
    LWU       = 6'b000110,
    LDU       = 6'b000111,
    SB        = 6'b001000,
    SH        = 6'b001001,
    SW        = 6'b001010,
    SD        = 6'b001011,
    LM        = 6'b001100,
    SM        = 6'b001101,
    AMOSWAP_W = 6'b100000,
    AMOADD_W  = 6'b100001,
    AMOXOR_W  = 6'b100010,
    AMOAND_W  = 6'b100011,
    AMOOR_W   = 6'b100100,
    AMOMIN_W  = 6'b100101,
    AMOMAX_W  = 6'b100110,
    AMOMINU_W = 6'b100111,
    AMOMAXU_W = 6'b101000,
    AMOSWAP_D = 6'b110000,
    AMOADD_D  = 6'b110001,
    AMOXOR_D  = 6'b110010,
    AMOAND_D  = 6'b110011,
    AMOOR_D   = 6'b110100,
    AMOMIN_D  = 6'b110101,
    AMOMAX_D  = 6'b110110,
    AMOMINU_D = 6'b110111,
    AMOMAXU_D = 6'b111000
  } opcode_e;

  typedef enum logic [3:0] {
    e_amo_swap = 4'b0000,
    e_amo_add  = 4'b0001,
    e_amo_xor  = 4'b0010,
    e_amo_and  = 4'b0011,
    e_amo_or   = 4'b0100,
    e_amo_min  = 4'b0101,
    e_amo_max  = 4'b0110,
    e_amo_minu = 4'b0111,
    e_amo_maxu = 4'b1000
  } amo_subop_e;

  typedef struct packed {
    opcode_e opcode;
    addr_t addr;
    data_t data;
    mask_t mask;
  } cache_pkt_s;

  typedef struct packed {
    size_e data_size_op;
    logic sigext_op;
    logic ld_op;
    logic st_op;
    logic mask_op;
    logic atomic_op;
    amo_subop_e amo_subop;
  } decode_s;

  // Byte offset of the lane, truncated to size alignment
  function automatic byte_off_t lane_offset(input size_e size, input addr_t addr);
    byte_off_t off;
    off = addr[byte_off_width_lp-1:0];
    case (size)
      e_size_half: off[0] = 1'b0;
      e_size_word: off[1:0] = 2'b00;
      e_size_double: off = '0;
      default: off = addr[byte_off_width_lp-1:0];
    endcase
    return off;
  endfunction

endpackage

// ==== rtl/scache_decode.sv ====
// Cache opcode decoder
// Maps an opcode to size, sign, load, store, mask and atomic flags
module scache_decode (
  input  scache_pkg::opcode_e opcode_i,
  output scache_pkg::decode_s decode_o
);

  logic signed_ld;

  assign signed_ld = (opcode_i == scache_pkg::LB)
    || (opcode_i == scache_pkg::LH)
    || (opcode_i == scache_pkg::LW)
    || (opcode_i == scache_pkg::LD);

  always_comb begin
    case (opcode_i)
      scache_pkg::AMOSWAP_D, scache_pkg::AMOADD_D, scache_pkg::AMOXOR_D,
      scache_pkg::AMOAND_D, scache_pkg::AMOOR_D, scache_pkg::AMOMIN_D,
      scache_pkg::AMOMAX_D, scache_pkg::AMOMINU_D, scache_pkg::AMOMAXU_D,
      scache_pkg::LD, scache_pkg::LDU, scache_pkg::SD:
        decode_o.data_size_op = scache_pkg::e_size_double;
      scache_pkg::AMOSWAP_W, scache_pkg::AMOADD_W, scache_pkg::AMOXOR_W,
      scache_pkg::AMOAND_W, scache_pkg::AMOOR_W, scache_pkg::AMOMIN_W,
      scache_pkg::AMOMAX_W, scache_pkg::AMOMINU_W, scache_pkg::AMOMAXU_W,
      scache_pkg::LW, scache_pkg::LWU, scache_pkg::SW:
        decode_o.data_size_op = scache_pkg::e_size_word;
      scache_pkg::LH, scache_pkg::LHU, scache_pkg::SH:
        decode_o.data_size_op = scache_pkg::e_size_half;
      default:
        decode_o.data_size_op = scache_pkg::e_size_byte;
    endcase

    decode_o.ld_op = signed_ld
      || (opcode_i == scache_pkg::LBU)
      || (opcode_i == scache_pkg::LHU)
      || (opcode_i == scache_pkg::LWU)
      || (opcode_i == scache_pkg::LDU)
      || (opcode_i == scache_pkg::LM);

    decode_o.st_op = (opcode_i == scache_pkg::SB)
      || (opcode_i == scache_pkg::SH)
      || (opcode_i == scache_pkg::SW)
      || (opcode_i == scache_pkg::SD)
      || (opcode_i == scache_pkg::SM);

    decode_o.mask_op = (opcode_i == scache_pkg::LM) || (opcode_i == scache_pkg::SM);

    // Atomics
    decode_o.atomic_op = 1'b1;
    case (opcode_i)
      scache_pkg::AMOSWAP_W, scache_pkg::AMOSWAP_D: decode_o.amo_subop = scache_pkg::e_amo_swap;
      scache_pkg::AMOADD_W, scache_pkg::AMOADD_D: decode_o.amo_subop = scache_pkg::e_amo_add;
      scache_pkg::AMOXOR_W, scache_pkg::AMOXOR_D: decode_o.amo_subop = scache_pkg::e_amo_xor;
      scache_pkg::AMOAND_W, scache_pkg::AMOAND_D: decode_o.amo_subop = scache_pkg::e_amo_and;
      scache_pkg::AMOOR_W, scache_pkg::AMOOR_D: decode_o.amo_subop = scache_pkg::e_amo_or;
      scache_pkg::AMOMIN_W, scache_pkg::AMOMIN_D: decode_o.amo_subop = scache_pkg::e_amo_min;
      scache_pkg::AMOMAX_W, scache_pkg::AMOMAX_D: decode_o.amo_subop = scache_pkg::e_amo_max;
      scache_pkg::AMOMINU_W, scache_pkg::AMOMINU_D: decode_o.amo_subop = scache_pkg::e_amo_minu;
      scache_pkg::AMOMAXU_W, scache_pkg::AMOMAXU_D: decode_o.amo_subop = scache_pkg::e_amo_maxu;
      default: begin
        decode_o.atomic_op = 1'b0;
        decode_o.amo_subop = scache_pkg::e_amo_swap;
      end
    endcase

    // Atomics return the old lane sign-extended
    decode_o.sigext_op = signed_ld || decode_o.atomic_op;
  end

endmodule

// ==== rtl/scache_amo_alu.sv ====
// Atomic operation ALU
// New memory value from the old lane and the operand
module scache_amo_alu (
  input  scache_pkg::amo_subop_e subop_i,
  input  scache_pkg::size_e      size_i,
  input  scache_pkg::data_t      mem_i,
  input  scache_pkg::data_t      operand_i,
  output scache_pkg::data_t      result_o
);

  logic is_double;
  logic lt_signed;
  logic lt_unsigned;

  assign is_double = (size_i == scache_pkg::e_size_double);

  // Word ops compare the low half only
  assign lt_signed = is_double
    ? ($signed(mem_i) < $signed(operand_i))
    : ($signed(mem_i[31:0]) < $signed(operand_i[31:0]));

  assign lt_unsigned = is_double
    ? (mem_i < operand_i)
    : (mem_i[31:0] < operand_i[31:0]);

  // Upper half of a word result is dropped by the store merge
  always_comb begin
    case (subop_i)
      scache_pkg::e_amo_swap: result_o = operand_i;
      scache_pkg::e_amo_add: result_o = mem_i + operand_i;
      scache_pkg::e_amo_xor: result_o = mem_i ^ operand_i;
      scache_pkg::e_amo_and: result_o = mem_i & operand_i;
      scache_pkg::e_amo_or: result_o = mem_i | operand_i;
      scache_pkg::e_amo_min: result_o = lt_signed ? mem_i : operand_i;
      scache_pkg::e_amo_max: result_o = lt_signed ? operand_i : mem_i;
      scache_pkg::e_amo_minu: result_o = lt_unsigned ? mem_i : operand_i;
      scache_pkg::e_amo_maxu: result_o = lt_unsigned ? operand_i : mem_i;
      default: result_o = operand_i;
    endcase
  end

endmodule

// ==== rtl/scache_ld_align.sv ====
// Load alignment
// Picks the addressed lane and extends it, or masks the word for LM
module scache_ld_align (
  input  scache_pkg::data_t   word_i,
  input  scache_pkg::addr_t   addr_i,
  input  scache_pkg::decode_s decode_i,
  input  scache_pkg::mask_t   mask_i,
  output scache_pkg::data_t   data_o
);

  scache_pkg::byte_off_t off;
  scache_pkg::data_t lane;
  scache_pkg::data_t bit_mask;
  logic sx;

  assign off = scache_pkg::lane_offset(decode_i.data_size_op, addr_i);
  assign lane = word_i >> {off, 3'b000};
  assign sx = decode_i.sigext_op;

  always_comb begin
    for (int i = 0; i < scache_pkg::mask_width_lp; i++) begin
      bit_mask[8*i +: 8] = {8{mask_i[i]}};
    end
  end

  always_comb begin
    if (decode_i.mask_op) begin
      data_o = word_i & bit_mask;
    end else begin
      case (decode_i.data_size_op)
        scache_pkg::e_size_byte: data_o = {{56{sx & lane[7]}}, lane[7:0]};
        scache_pkg::e_size_half: data_o = {{48{sx & lane[15]}}, lane[15:0]};
        scache_pkg::e_size_word: data_o = {{32{sx & lane[31]}}, lane[31:0]};
        default: data_o = lane;
      endcase
    end
  end

endmodule

// ==== rtl/scache_st_merge.sv ====
// Store merge
// Byte enables and lane-replicated write data for stores and atomics
module scache_st_merge (
  input  scache_pkg::data_t   data_i,
  input  scache_pkg::addr_t   addr_i,
  input  scache_pkg::decode_s decode_i,
  input  scache_pkg::mask_t   mask_i,
  output scache_pkg::mask_t   be_o,
  output scache_pkg::data_t   wdata_o
);

  scache_pkg::byte_off_t off;
  scache_pkg::mask_t be_base;
  scache_pkg::data_t lane_data;

  assign off = scache_pkg::lane_offset(decode_i.data_size_op, addr_i);

  // Lane copied into every slot, enables pick the right one
  always_comb begin
    case (decode_i.data_size_op)
      scache_pkg::e_size_byte: begin
        lane_data = {8{data_i[7:0]}};
        be_base = 8'b0000_0001;
      end
      scache_pkg::e_size_half: begin
        lane_data = {4{data_i[15:0]}};
        be_base = 8'b0000_0011;
      end
      scache_pkg::e_size_word: begin
        lane_data = {2{data_i[31:0]}};
        be_base = 8'b0000_1111;
      end
      default: begin
        lane_data = data_i;
        be_base = 8'b1111_1111;
      end
    endcase
  end

  assign be_o = decode_i.mask_op ? mask_i : scache_pkg::mask_t'(be_base << off);
  assign wdata_o = decode_i.mask_op ? data_i : lane_data;

endmodule

// ==== rtl/scache_data_mem.sv ====
// Single-bank data store
// Combinational read, per-byte synchronous write
module scache_data_mem (
  input  logic                  clk_i,
  input  scache_pkg::word_idx_t rd_idx_i,
  output scache_pkg::data_t     rd_data_o,
  input  scache_pkg::mask_t     we_i,
  input  scache_pkg::word_idx_t wr_idx_i,
  input  scache_pkg::data_t     wr_data_i
);

  scache_pkg::data_t mem_r [scache_pkg::mem_depth_lp];

  assign rd_data_o = mem_r[rd_idx_i];

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < scache_pkg::mask_width_lp; i++) begin
      if (we_i[i]) begin
        mem_r[wr_idx_i][8*i +: 8] <= wr_data_i[8*i +: 8];
      end
    end
  end

endmodule

// ==== rtl/scache_core.sv ====
// Cache execute pipeline
// Packet register, decode and data path, then result register
module scache_core (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   v_i,
  input  scache_pkg::cache_pkt_s pkt_i,
  output scache_pkg::word_idx_t  rd_idx_o,
  input  scache_pkg::data_t      rd_data_i,
  output scache_pkg::mask_t      we_o,
  output scache_pkg::word_idx_t  wr_idx_o,
  output scache_pkg::data_t      wr_data_o,
  output logic                   v_o,
  output scache_pkg::data_t      data_o
);

  scache_pkg::cache_pkt_s s1_pkt_r;
  logic s1_v_r;
  scache_pkg::decode_s s1_dec;
  scache_pkg::data_t ld_data;
  scache_pkg::data_t amo_result;
  scache_pkg::data_t st_data;
  scache_pkg::mask_t be;
  scache_pkg::data_t result;
  logic write_op;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_v_r <= 1'b0;
    end else begin
      s1_v_r <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      s1_pkt_r <= pkt_i;
    end
  end

  scache_decode decode_i (
    .opcode_i(s1_pkt_r.opcode),
    .decode_o(s1_dec)
  );

  assign rd_idx_o = s1_pkt_r.addr[scache_pkg::addr_width_lp-1:scache_pkg::byte_off_width_lp];

  // Old lane also feeds the ALU for atomics
  scache_ld_align ld_align_i (
    .word_i  (rd_data_i),
    .addr_i  (s1_pkt_r.addr),
    .decode_i(s1_dec),
    .mask_i  (s1_pkt_r.mask),
    .data_o  (ld_data)
  );

  scache_amo_alu amo_alu_i (
    .subop_i  (s1_dec.amo_subop),
    .size_i   (s1_dec.data_size_op),
    .mem_i    (ld_data),
    .operand_i(s1_pkt_r.data),
    .result_o (amo_result)
  );

  assign st_data = s1_dec.atomic_op ? amo_result : s1_pkt_r.data;

  scache_st_merge st_merge_i (
    .data_i  (st_data),
    .addr_i  (s1_pkt_r.addr),
    .decode_i(s1_dec),
    .mask_i  (s1_pkt_r.mask),
    .be_o    (be),
    .wdata_o (wr_data_o)
  );

  assign write_op = s1_v_r && (s1_dec.st_op || s1_dec.atomic_op);
  assign we_o = write_op ? be : '0;
  assign wr_idx_o = rd_idx_o;

  // Stores return zero
  assign result = (s1_dec.ld_op || s1_dec.atomic_op) ? ld_data : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= s1_v_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_v_r) begin
      data_o <= result;
    end
  end

endmodule

// ==== rtl/scache_top.sv ====
// Data cache slice top
// Execute pipeline and its word store
module scache_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   v_i,
  input  scache_pkg::cache_pkt_s pkt_i,
  output logic                   v_o,
  output scache_pkg::data_t      data_o
);

  scache_pkg::word_idx_t rd_idx;
  scache_pkg::data_t rd_data;
  scache_pkg::mask_t we;
  scache_pkg::word_idx_t wr_idx;
  scache_pkg::data_t wr_data;

  scache_core core_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .v_i      (v_i),
    .pkt_i    (pkt_i),
    .rd_idx_o (rd_idx),
    .rd_data_i(rd_data),
    .we_o     (we),
    .wr_idx_o (wr_idx),
    .wr_data_o(wr_data),
    .v_o      (v_o),
    .data_o   (data_o)
  );

  scache_data_mem data_mem_i (
    .clk_i    (clk_i),
    .rd_idx_i (rd_idx),
    .rd_data_o(rd_data),
    .we_i     (we),
    .wr_idx_i (wr_idx),
    .wr_data_i(wr_data)
  );

endmodule

// ==== dv/scache_sva.sv ====
// Timing assertions for the cache execute core
// Valid latency, reset behavior and known result data
module scache_sva (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              v_i,
  input logic              v_o,
  input scache_pkg::data_t data_o
);

  // Every packet returns exactly two cycles later, and nothing else does
  assert property (@(posedge clk_i) disable iff (!rst_n_i) v_o == $past(v_i, 2))
    else $error("v_o does not follow v_i by two cycles");

  assert property (@(posedge clk_i) !rst_n_i |=> !v_o)
    else $error("v_o is high in the cycle after reset");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) v_o |-> !$isunknown(data_o))
    else $error("data_o has unknown bits while v_o is high");

endmodule

// ==== dv/scache_checker.sv ====
// Result checker for the cache slice
// Queues the golden result of each accepted packet, compares it on v_o
module scache_checker (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              v_i,
  input  logic [127:0]      name_i,
  input  scache_pkg::data_t expected_i,
  input  logic              dut_v_i,
  input  scache_pkg::data_t dut_data_i,
  output int                checked_o,
  output int                errors_o,
  output int                pending_o
);

  typedef struct packed {
    logic [127:0] name;
    scache_pkg::data_t data;
  } expect_s;

  expect_s expect_q [$];
  expect_s head;
  expect_s entry;

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      expect_q.delete();
      checked_o = 0;
      errors_o = 0;
    end else begin
      // DUT outputs still hold their values from before this edge
      if (dut_v_i) begin
        if (expect_q.size() == 0) begin
          $display("Error: v_o without a pending test, data_o %h", dut_data_i);
          errors_o = errors_o + 1;
        end else begin
          head = expect_q.pop_front();
          checked_o = checked_o + 1;
          if (dut_data_i !== head.data) begin
            $display("Error %0s: expected %h, actual %h", head.name, head.data, dut_data_i);
            errors_o = errors_o + 1;
          end else begin
            $display("ok    %0s: %h", head.name, dut_data_i);
          end
        end
      end
      if (v_i) begin
        entry.name = name_i;
        entry.data = expected_i;
        expect_q.push_back(entry);
      end
    end
    pending_o = expect_q.size();
  end

endmodule

// ==== dv/scache_tb.sv ====
// Data cache slice testbench
// Golden-file packets with random idle gaps, results checked by scache_checker
module scache_tb;

  typedef struct packed {
    logic [127:0] name;
    scache_pkg::cache_pkt_s pkt;
    scache_pkg::data_t expected;
  } test_s;

  logic clk_i;
  logic rst_n_i;
  logic v_i;
  scache_pkg::cache_pkt_s pkt_i;
  logic v_o;
  scache_pkg::data_t data_o;
  logic [127:0] name_r;
  scache_pkg::data_t expected_r;
  int checked;
  int errors;
  int pending;
  int bad_lines;
  int gap;
  logic loaded;
  logic [31:0] lcg_state;
  test_s tests_q [$];

  scache_top scache_top_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .v_i    (v_i),
    .pkt_i  (pkt_i),
    .v_o    (v_o),
    .data_o (data_o)
  );

  scache_checker checker_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .v_i       (v_i),
    .name_i    (name_r),
    .expected_i(expected_r),
    .dut_v_i   (v_o),
    .dut_data_i(data_o),
    .checked_o (checked),
    .errors_o  (errors),
    .pending_o (pending)
  );

  bind scache_core scache_sva sva_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .v_i    (v_i),
    .v_o    (v_o),
    .data_o (data_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Names are right-aligned, so find the first character before matching
  function automatic bit no_gap(input logic [127:0] name);
    bit found;
    bit result;
    found = 1'b0;
    result = 1'b0;
    for (int i = 15; i >= 2; i--) begin
      if (!found && name[8*i +: 8] != 8'h00) begin
        found = 1'b1;
        result = (name[8*(i-2) +: 24] == "b2b");
      end
    end
    return result;
  endfunction

  task automatic hold_reset();
    rst_n_i = 1'b0;
    v_i = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
  endtask

  task automatic load_golden();
    int fd;
    int n;
    string line;
    logic [127:0] name;
    logic [5:0] op;
    scache_pkg::addr_t addr;
    scache_pkg::data_t data;
    scache_pkg::mask_t mask;
    scache_pkg::data_t expected;
    test_s t;
    fd = $fopen("dv/scache_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open dv/scache_golden.txt");
      bad_lines = bad_lines + 1;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h", name, op, addr, data, mask, expected);
          if (n == 6) begin
            t.name = name;
            t.pkt.opcode = scache_pkg::opcode_e'(op);
            t.pkt.addr = addr;
            t.pkt.data = data;
            t.pkt.mask = mask;
            t.expected = expected;
            tests_q.push_back(t);
          end else begin
            $display("Malformed line in golden file: %s", line);
            bad_lines = bad_lines + 1;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    v_i = 1'b0;
    pkt_i = '0;
    name_r = '0;
    expected_r = '0;
    bad_lines = 0;
    lcg_state = 32'h9bb0_080b;
    load_golden();
    loaded = 1'b1;
    hold_reset();
    // Second reset while two stores to word 0 are in flight
    pkt_i.opcode = scache_pkg::SD;
    v_i = 1'b1;
    repeat (2) @(negedge clk_i);
    hold_reset();
    pkt_i = '0;
    foreach (tests_q[i]) begin
      lcg_state = lcg_next(lcg_state);
      gap = no_gap(tests_q[i].name) ? 0 : int'(lcg_state[31:30]);
      repeat (gap) begin
        v_i = 1'b0;
        @(negedge clk_i);
      end
      v_i = 1'b1;
      pkt_i = tests_q[i].pkt;
      name_r = tests_q[i].name;
      expected_r = tests_q[i].expected;
      @(negedge clk_i);
    end
    v_i = 1'b0;
    while (pending != 0) @(negedge clk_i);
    // A few more cycles to catch a stray v_o
    repeat (3) @(negedge clk_i);
    $display("checked %0d of %0d tests, %0d errors, %0d never returned",
             checked, tests_q.size(), errors, pending);
    if (errors == 0 && bad_lines == 0 && tests_q.size() > 0 && checked == tests_q.size()) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog sized from the number of tests
  initial begin
    wait (loaded);
    repeat (tests_q.size() * 6 + 20) @(posedge clk_i);
    $display("Timeout: results still missing after %0d cycles", tests_q.size() * 6 + 20);
    $display("test failed");
    $finish;
  end

endmodule

// ==== dv/scache_golden.txt ====
# name opcode addr data mask expected, all hex
# opcode is the 6-bit opcode_e value, expected is the returned data_o
sd_init    0b 008 1122334455667788 00 0000000000000000
sw_lane0   0a 008 ffffffffdeadbeef 00 0000000000000000
sh_lane2   09 00c 000000000000bbcc 00 0000000000000000
sb_lane7   08 00f 123456789abcdeaa 00 0000000000000000
ld_stores  03 008 0000000000000000 00 aa22bbccdeadbeef
lb_neg     00 00f 0000000000000000 00 ffffffffffffffaa
lbu_neg    04 00f 0000000000000000 00 00000000000000aa
lh_neg     01 00c 0000000000000000 00 ffffffffffffbbcc
lhu_misal  05 00d 0000000000000000 00 000000000000bbcc
lw_neg     02 008 0000000000000000 00 ffffffffdeadbeef
lwu_misal  06 00a 0000000000000000 00 00000000deadbeef
sd_mask    0b 010 0123456789abcdef 00 0000000000000000
sm_5a      0d 010 ffeeddccbbaa9988 5a 0000000000000000
ld_sm      03 010 0000000000000000 00 01ee45ccbbab99ef
lm_0f      0c 010 0000000000000000 0f 00000000bbab99ef
amoswap_w  20 008 0000000012345678 00 ffffffffdeadbeef
amoadd_w   21 008 0000000011111111 00 0000000012345678
amoxor_w   22 008 00000000ffff0000 00 0000000023456789
amoand_w   23 008 00000000f0f0f0f0 00 ffffffffdcba6789
amoor_w    24 008 000000000000000f 00 ffffffffd0b06080
amomax_w   26 008 0000000000000005 00 ffffffffd0b0608f
amomin_w   25 008 0000000080000000 00 0000000000000005
amominu_w  27 008 0000000000000007 00 ffffffff80000000
amomaxu_w  28 008 00000000fffffff0 00 0000000000000007
ld_amo_w   03 008 0000000000000000 00 aa22bbccfffffff0
amoswap_d  30 010 8000000000000010 00 01ee45ccbbab99ef
amoadd_d   31 010 0000000000000020 00 8000000000000010
amoxor_d   32 010 00000000ffffffff 00 8000000000000030
amoand_d   33 010 f00000000000ff00 00 80000000ffffffcf
amoor_d    34 010 0000000100000001 00 800000000000ff00
amomax_d   36 010 0000000000000003 00 800000010000ff01
amomin_d   35 010 fffffffffffffffe 00 0000000000000003
amominu_d  37 010 0000000000000009 00 fffffffffffffffe
amomaxu_d  38 010 8000000000000000 00 0000000000000009
ld_amo_d   03 010 0000000000000000 00 8000000000000000
b2b_sd     0b 018 0f1e2d3c4b5a6978 00 0000000000000000
b2b_ld     03 018 0000000000000000 00 0f1e2d3c4b5a6978
b2b_sb     08 01d 0000000000000055 00 0000000000000000
b2b_lbu    04 01d 0000000000000000 00 0000000000000055
b2b_amoadd 31 018 0000000000000001 00 0f1e553c4b5a6978
b2b_ld2    03 018 0000000000000000 00 0f1e553c4b5a6979

// ==== build.f ====
rtl/scache_pkg.sv
rtl/scache_decode.sv
rtl/scache_amo_alu.sv
rtl/scache_ld_align.sv
rtl/scache_st_merge.sv
rtl/scache_data_mem.sv
rtl/scache_core.sv
rtl/scache_top.sv
dv/scache_sva.sv
dv/scache_checker.sv
dv/scache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run, success only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f build.f --top-module scache_tb -o scache_sim \
  && ./obj_dir/scache_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -qx "test passed" sim.log \
  || { echo "simulation did not pass"; exit 1; }
